//--- design/decode_config.svh
// ==========================================================
// Widths shared by the decode stage. Only RV32 is handled,
// so DEC_XLEN must stay 32
// ==========================================================
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_XLEN         32
`define DEC_WID_BITS     2
`define DEC_NUM_THREADS  4  // Thread mask width
`define DEC_REG_BITS     5

`endif

//--- design/rv_isa_pkg.sv
// ==========================================================
// RV32I encodings used by the decoder. Only base integer,
// FENCE, Zicsr and the ECALL/EBREAK/MRET traps are covered
// ==========================================================
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_PC4
    } imm_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_JAL, BR_JALR, BR_ECALL, BR_EBREAK, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        CSR_RW = 4'd1,
        CSR_RS = 4'd2,
        CSR_RC = 4'd3
    } csr_op_e;

    localparam logic [3:0]  LSU_FENCE  = 4'd15;  // Loads and stores use {store, funct3}

    // 12-bit system field values
    localparam logic [11:0] SYS_ECALL  = 12'h000;
    localparam logic [11:0] SYS_EBREAK = 12'h001;
    localparam logic [11:0] SYS_MRET   = 12'h302;
    localparam logic [11:0] CSR_FCSR   = 12'h003;  // Highest FPU CSR

endpackage

`default_nettype wire

//--- design/decode_pkg.sv
// ==========================================================
// Decode stage output types. Register numbers in the record
// are raw instruction fields; used_rs tells which are read
// ==========================================================
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    typedef enum logic [2:0] {
        EX_NONE   = 3'd0,
        EX_ALU    = 3'd1,
        EX_BRANCH = 3'd2,
        EX_LSU    = 3'd3,
        EX_CSR    = 3'd4
    } ex_unit_e;

    typedef struct packed {
        ex_unit_e                     ex_unit;
        logic [3:0]                   op_type;  // Unit specific
        logic                         use_imm;
        logic                         use_pc;
        logic [`DEC_XLEN-1:0]         imm;
        logic                         wb;
        logic [`DEC_REG_BITS-1:0]     rd;
        logic [`DEC_REG_BITS-1:0]     rs1;
        logic [`DEC_REG_BITS-1:0]     rs2;
        logic [1:0]                   used_rs;  // {rs2, rs1}
        logic [`DEC_XLEN-1:0]         pc;
        logic [`DEC_WID_BITS-1:0]     wid;
        logic [`DEC_NUM_THREADS-1:0]  tmask;
    } decoded_t;

endpackage

`default_nettype wire

//--- design/dec_ctrl_if.sv
// ==========================================================
// Opcode classification from the controller to the field
// decoders. Combinational only, valid in the fetch cycle
// ==========================================================
`default_nettype none

interface dec_ctrl_if;

    decode_pkg::ex_unit_e  ex_unit;
    rv_isa_pkg::imm_fmt_e  imm_fmt;
    logic                  use_pc;
    logic                  use_imm;
    logic                  use_rd;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  wstall;  // Warp must wait for this one

    modport ctrl (
        output ex_unit, imm_fmt, use_pc, use_imm, use_rd, use_rs1, use_rs2, wstall
    );

    modport dp (
        input ex_unit, imm_fmt, use_pc, use_imm, use_rd, use_rs1, use_rs2, wstall
    );

endinterface

`default_nettype wire

//--- design/decode_ctrl.sv
// ==========================================================
// Major opcode classifier. Anything outside RV32I, FENCE,
// Zicsr and ECALL/EBREAK/MRET decodes as unit NONE
// ==========================================================
`default_nettype none

module decode_ctrl (
    input  wire [31:0]   instr,
    dec_ctrl_if.ctrl     ctrl,
    output logic         wb
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [11:0]         sys_field;

    assign opcode    = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign sys_field = instr[31:20];

    always_comb begin
        ctrl.ex_unit = decode_pkg::EX_NONE;
        ctrl.imm_fmt = rv_isa_pkg::IMM_NONE;
        ctrl.use_pc  = 1'b0;
        ctrl.use_imm = 1'b0;
        ctrl.use_rd  = 1'b0;
        ctrl.use_rs1 = 1'b0;
        ctrl.use_rs2 = 1'b0;
        ctrl.wstall  = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                ctrl.ex_unit = decode_pkg::EX_ALU;
                // SLLI, SRLI, SRAI take a shift amount
                ctrl.imm_fmt = (funct3[1:0] == 2'b01) ? rv_isa_pkg::IMM_SHAMT
                                                      : rv_isa_pkg::IMM_I;
                ctrl.use_imm = 1'b1;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
            end
            rv_isa_pkg::OPC_OP: begin
                ctrl.ex_unit = decode_pkg::EX_ALU;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
            end
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
                ctrl.ex_unit = decode_pkg::EX_ALU;
                ctrl.imm_fmt = rv_isa_pkg::IMM_U;
                ctrl.use_imm = 1'b1;
                ctrl.use_pc  = instr[5] == 1'b0;  // AUIPC
                ctrl.use_rd  = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.ex_unit = decode_pkg::EX_BRANCH;
                ctrl.imm_fmt = rv_isa_pkg::IMM_J;
                ctrl.use_imm = 1'b1;
                ctrl.use_pc  = 1'b1;
                ctrl.use_rd  = 1'b1;
                ctrl.wstall  = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.ex_unit = decode_pkg::EX_BRANCH;
                ctrl.imm_fmt = rv_isa_pkg::IMM_I;
                ctrl.use_imm = 1'b1;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.wstall  = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin  // funct3 2 and 3 are reserved
                    ctrl.ex_unit = decode_pkg::EX_BRANCH;
                    ctrl.imm_fmt = rv_isa_pkg::IMM_B;
                    ctrl.use_imm = 1'b1;
                    ctrl.use_pc  = 1'b1;
                    ctrl.use_rs1 = 1'b1;
                    ctrl.use_rs2 = 1'b1;
                    ctrl.wstall  = 1'b1;
                end
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.ex_unit = decode_pkg::EX_LSU;
                ctrl.imm_fmt = rv_isa_pkg::IMM_I;
                ctrl.use_imm = 1'b1;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.ex_unit = decode_pkg::EX_LSU;
                ctrl.imm_fmt = rv_isa_pkg::IMM_S;
                ctrl.use_imm = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
            end
            rv_isa_pkg::OPC_MISC_MEM: ctrl.ex_unit = decode_pkg::EX_LSU;  // FENCE
            rv_isa_pkg::OPC_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin
                    ctrl.ex_unit = decode_pkg::EX_CSR;
                    ctrl.imm_fmt = rv_isa_pkg::IMM_CSR;
                    ctrl.use_imm = funct3[2];  // zimm sits in the rs1 field
                    ctrl.use_rd  = 1'b1;
                    ctrl.use_rs1 = !funct3[2];
                    ctrl.wstall  = sys_field <= rv_isa_pkg::CSR_FCSR;
                end else if (funct3 == 3'b000 && (sys_field == rv_isa_pkg::SYS_ECALL ||
                             sys_field == rv_isa_pkg::SYS_EBREAK ||
                             sys_field == rv_isa_pkg::SYS_MRET)) begin
                    ctrl.ex_unit = decode_pkg::EX_BRANCH;
                    ctrl.imm_fmt = rv_isa_pkg::IMM_PC4;
                    ctrl.use_imm = 1'b1;
                    ctrl.use_pc  = 1'b1;
                    ctrl.use_rd  = 1'b1;
                    ctrl.wstall  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign wb = ctrl.use_rd && (instr[11:7] != 5'd0);  // x0 never written

endmodule

`default_nettype wire

//--- design/imm_gen.sv
// ==========================================================
// Immediate builder. Sign extends every format except the
// shift amount and the CSR address, which are zero extended
// ==========================================================
`default_nettype none

`include "decode_config.svh"

module imm_gen (
    input  wire [31:0]          instr,
    dec_ctrl_if.dp              ctrl,
    output logic [`DEC_XLEN-1:0] imm
);

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [31:0] u_imm;
    logic [20:0] j_imm;

    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (ctrl.imm_fmt)
            rv_isa_pkg::IMM_I:     imm = `DEC_XLEN'($signed(i_imm));
            rv_isa_pkg::IMM_SHAMT: imm = `DEC_XLEN'(instr[24:20]);
            rv_isa_pkg::IMM_S:     imm = `DEC_XLEN'($signed(s_imm));
            rv_isa_pkg::IMM_B:     imm = `DEC_XLEN'($signed(b_imm));
            rv_isa_pkg::IMM_U:     imm = `DEC_XLEN'($signed(u_imm));
            rv_isa_pkg::IMM_J:     imm = `DEC_XLEN'($signed(j_imm));
            rv_isa_pkg::IMM_CSR:   imm = `DEC_XLEN'(i_imm);
            rv_isa_pkg::IMM_PC4:   imm = `DEC_XLEN'(4);  // Return address of a trap
            default:               imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/op_decode.sv
// ==========================================================
// Operation code per execution unit. Relies on the
// controller to reject reserved branch and system encodings
// ==========================================================
`default_nettype none

module op_decode (
    input  wire [31:0]  instr,
    dec_ctrl_if.dp      ctrl,
    output logic [3:0]  op_type
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [3:0]          alu_op;
    logic [3:0]          br_op;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        case (funct3)
            3'h0: begin
                if (!ctrl.use_imm && funct7[5]) begin  // SUB exists only as R-type
                    alu_op = rv_isa_pkg::ALU_SUB;
                end else begin
                    alu_op = rv_isa_pkg::ALU_ADD;
                end
            end
            3'h1: alu_op = rv_isa_pkg::ALU_SLL;
            3'h2: alu_op = rv_isa_pkg::ALU_SLT;
            3'h3: alu_op = rv_isa_pkg::ALU_SLTU;
            3'h4: alu_op = rv_isa_pkg::ALU_XOR;
            3'h5: alu_op = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'h6: alu_op = rv_isa_pkg::ALU_OR;
            default: alu_op = rv_isa_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_JAL:  br_op = rv_isa_pkg::BR_JAL;
            rv_isa_pkg::OPC_JALR: br_op = rv_isa_pkg::BR_JALR;
            rv_isa_pkg::OPC_SYSTEM: begin
                if (instr[31:20] == rv_isa_pkg::SYS_MRET) begin
                    br_op = rv_isa_pkg::BR_MRET;
                end else if (instr[20]) begin
                    br_op = rv_isa_pkg::BR_EBREAK;
                end else begin
                    br_op = rv_isa_pkg::BR_ECALL;
                end
            end
            default: begin
                case (funct3)
                    3'h1: br_op = rv_isa_pkg::BR_BNE;
                    3'h4: br_op = rv_isa_pkg::BR_BLT;
                    3'h5: br_op = rv_isa_pkg::BR_BGE;
                    3'h6: br_op = rv_isa_pkg::BR_BLTU;
                    3'h7: br_op = rv_isa_pkg::BR_BGEU;
                    default: br_op = rv_isa_pkg::BR_BEQ;
                endcase
            end
        endcase
    end

    always_comb begin
        case (ctrl.ex_unit)
            decode_pkg::EX_ALU: begin
                if (opcode == rv_isa_pkg::OPC_LUI) begin
                    op_type = rv_isa_pkg::ALU_LUI;
                end else if (opcode == rv_isa_pkg::OPC_AUIPC) begin
                    op_type = rv_isa_pkg::ALU_AUIPC;
                end else begin
                    op_type = alu_op;
                end
            end
            decode_pkg::EX_BRANCH: op_type = br_op;
            decode_pkg::EX_LSU: begin
                op_type = (opcode == rv_isa_pkg::OPC_MISC_MEM) ? rv_isa_pkg::LSU_FENCE
                                                               : {instr[5], funct3};
            end
            decode_pkg::EX_CSR: op_type = {2'b00, funct3[1:0]};
            default: op_type = 4'd0;
        endcase
    end

    // Controller must have filtered out the reserved branch codes
    always_comb begin
        if (ctrl.ex_unit == decode_pkg::EX_BRANCH && ctrl.imm_fmt == rv_isa_pkg::IMM_B) begin
            assert (funct3[2:1] != 2'b01)
                else $error("branch decoded with reserved funct3 %0d", funct3);
        end
    end

endmodule

`default_nettype wire

//--- design/decode_out_buf.sv
// ==========================================================
// One-entry output register. Accepts while empty or while
// the held record is taken, so it runs at one per cycle
// ==========================================================
`default_nettype none

module decode_out_buf (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    output logic                  in_ready,
    input  wire decode_pkg::decoded_t in_data,
    output logic                  out_valid,
    input  wire                   out_ready,
    output decode_pkg::decoded_t  out_data
);

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // Held record must not change under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("decode output changed while stalled");

endmodule

`default_nettype wire

//--- design/decode_top.sv
// ==========================================================
// Decode stage top. sched_* is only meaningful in the cycle
// of a fetch transfer and has no handshake of its own
// ==========================================================
`default_nettype none

`include "decode_config.svh"

module decode_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          fetch_valid,
    output logic                         fetch_ready,
    input  wire [31:0]                   fetch_instr,
    input  wire [`DEC_XLEN-1:0]          fetch_pc,
    input  wire [`DEC_WID_BITS-1:0]      fetch_wid,
    input  wire [`DEC_NUM_THREADS-1:0]   fetch_tmask,
    output logic                         dec_valid,
    input  wire                          dec_ready,
    output decode_pkg::ex_unit_e         dec_ex_unit,
    output logic [3:0]                   dec_op_type,
    output logic                         dec_use_imm,
    output logic                         dec_use_pc,
    output logic [`DEC_XLEN-1:0]         dec_imm,
    output logic                         dec_wb,
    output logic [`DEC_REG_BITS-1:0]     dec_rd,
    output logic [`DEC_REG_BITS-1:0]     dec_rs1,
    output logic [`DEC_REG_BITS-1:0]     dec_rs2,
    output logic [1:0]                   dec_used_rs,
    output logic [`DEC_XLEN-1:0]         dec_pc,
    output logic [`DEC_WID_BITS-1:0]     dec_wid,
    output logic [`DEC_NUM_THREADS-1:0]  dec_tmask,
    output logic                         sched_valid,
    output logic [`DEC_WID_BITS-1:0]     sched_wid,
    output logic                         sched_unlock
);

    dec_ctrl_if           ctrl_if ();
    decode_pkg::decoded_t dec_in;
    decode_pkg::decoded_t dec_out;
    logic                 wb;
    logic [`DEC_XLEN-1:0] imm;
    logic [3:0]           op_type;

    decode_ctrl i_ctrl (.instr(fetch_instr), .ctrl(ctrl_if.ctrl), .wb(wb));

    imm_gen i_imm_gen (.instr(fetch_instr), .ctrl(ctrl_if.dp), .imm(imm));

    op_decode i_op_decode (.instr(fetch_instr), .ctrl(ctrl_if.dp), .op_type(op_type));

    always_comb begin
        dec_in.ex_unit = ctrl_if.ex_unit;
        dec_in.op_type = op_type;
        dec_in.use_imm = ctrl_if.use_imm;
        dec_in.use_pc  = ctrl_if.use_pc;
        dec_in.imm     = imm;
        dec_in.wb      = wb;
        dec_in.rd      = fetch_instr[11:7];
        dec_in.rs1     = fetch_instr[19:15];
        dec_in.rs2     = fetch_instr[24:20];
        dec_in.used_rs = {ctrl_if.use_rs2, ctrl_if.use_rs1};
        dec_in.pc      = fetch_pc;
        dec_in.wid     = fetch_wid;
        dec_in.tmask   = fetch_tmask;
    end

    decode_out_buf i_out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_data   (dec_in),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_out)
    );

    assign dec_ex_unit = dec_out.ex_unit;
    assign dec_op_type = dec_out.op_type;
    assign dec_use_imm = dec_out.use_imm;
    assign dec_use_pc  = dec_out.use_pc;
    assign dec_imm     = dec_out.imm;
    assign dec_wb      = dec_out.wb;
    assign dec_rd      = dec_out.rd;
    assign dec_rs1     = dec_out.rs1;
    assign dec_rs2     = dec_out.rs2;
    assign dec_used_rs = dec_out.used_rs;
    assign dec_pc      = dec_out.pc;
    assign dec_wid     = dec_out.wid;
    assign dec_tmask   = dec_out.tmask;

    // Scheduler sees the accepted instruction right away
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_wid;
    assign sched_unlock = !ctrl_if.wstall;

endmodule

`default_nettype wire

//--- test/tb_decode.sv
// ==========================================================
// Decode stage testbench. Cases come from the data file and
// are fed with random gaps against a randomly stalled output
// ==========================================================
`default_nettype none

`include "decode_config.svh"

module tb_decode;

    localparam int PERIOD        = 100;
    localparam int MAX_CASES     = 64;
    localparam int NUM_COLS      = 15;
    localparam int READY_TIMEOUT = 50;
    localparam int IDLE_TIMEOUT  = 100;

    // Columns of the cases file
    localparam int COL_INSTR   = 0;
    localparam int COL_PC      = 1;
    localparam int COL_WID     = 2;
    localparam int COL_TMASK   = 3;
    localparam int COL_UNIT    = 4;
    localparam int COL_OP      = 5;
    localparam int COL_USE_IMM = 6;
    localparam int COL_USE_PC  = 7;
    localparam int COL_IMM     = 8;
    localparam int COL_WB      = 9;
    localparam int COL_RD      = 10;
    localparam int COL_RS1     = 11;
    localparam int COL_RS2     = 12;
    localparam int COL_USED_RS = 13;
    localparam int COL_UNLOCK  = 14;

    logic                          clk;
    logic                          rst_n;
    logic                          fetch_valid;
    logic                          fetch_ready;
    logic [31:0]                   fetch_instr;
    logic [`DEC_XLEN-1:0]          fetch_pc;
    logic [`DEC_WID_BITS-1:0]      fetch_wid;
    logic [`DEC_NUM_THREADS-1:0]   fetch_tmask;
    logic                          dec_valid;
    logic                          dec_ready;
    decode_pkg::ex_unit_e          dec_ex_unit;
    logic [3:0]                    dec_op_type;
    logic                          dec_use_imm;
    logic                          dec_use_pc;
    logic [`DEC_XLEN-1:0]          dec_imm;
    logic                          dec_wb;
    logic [`DEC_REG_BITS-1:0]      dec_rd;
    logic [`DEC_REG_BITS-1:0]      dec_rs1;
    logic [`DEC_REG_BITS-1:0]      dec_rs2;
    logic [1:0]                    dec_used_rs;
    logic [`DEC_XLEN-1:0]          dec_pc;
    logic [`DEC_WID_BITS-1:0]      dec_wid;
    logic [`DEC_NUM_THREADS-1:0]   dec_tmask;
    logic                          sched_valid;
    logic [`DEC_WID_BITS-1:0]      sched_wid;
    logic                          sched_unlock;

    logic [31:0] case_tbl [MAX_CASES][NUM_COLS];
    int          n_cases;
    int          received;
    int          expected[$];   // Case indices in acceptance order
    logic [31:0] prod_lfsr;
    logic [31:0] cons_lfsr;

    decode_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            fail_run("decoded value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_bit(inout logic [31:0] state, output logic b);
        state = lfsr_step(state);
        b     = state[0];
    endtask

    task automatic load_cases();
        int    fd;
        int    code;
        string line;
        fd = $fopen("test/decode_cases.txt", "r");
        if (fd == 0) fail_run("cannot open test/decode_cases.txt");
        n_cases = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;  // Comments, blanks
            if (n_cases >= MAX_CASES) fail_run("too many lines in the cases file");
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                case_tbl[n_cases][0], case_tbl[n_cases][1], case_tbl[n_cases][2],
                case_tbl[n_cases][3], case_tbl[n_cases][4], case_tbl[n_cases][5],
                case_tbl[n_cases][6], case_tbl[n_cases][7], case_tbl[n_cases][8],
                case_tbl[n_cases][9], case_tbl[n_cases][10], case_tbl[n_cases][11],
                case_tbl[n_cases][12], case_tbl[n_cases][13], case_tbl[n_cases][14]);
            if (code != NUM_COLS) fail_run("malformed line in the cases file");
            n_cases++;
        end
        $fclose(fd);
        if (n_cases == 0) fail_run("the cases file holds no instructions");
    endtask

    task automatic compare_record(input int idx);
        check_value("dec_ex_unit", 64'(dec_ex_unit), 64'(case_tbl[idx][COL_UNIT]));
        check_value("dec_op_type", 64'(dec_op_type), 64'(case_tbl[idx][COL_OP]));
        check_value("dec_use_imm", 64'(dec_use_imm), 64'(case_tbl[idx][COL_USE_IMM]));
        check_value("dec_use_pc", 64'(dec_use_pc), 64'(case_tbl[idx][COL_USE_PC]));
        check_value("dec_imm", 64'(dec_imm), 64'(case_tbl[idx][COL_IMM]));
        check_value("dec_wb", 64'(dec_wb), 64'(case_tbl[idx][COL_WB]));
        check_value("dec_rd", 64'(dec_rd), 64'(case_tbl[idx][COL_RD]));
        check_value("dec_rs1", 64'(dec_rs1), 64'(case_tbl[idx][COL_RS1]));
        check_value("dec_rs2", 64'(dec_rs2), 64'(case_tbl[idx][COL_RS2]));
        check_value("dec_used_rs", 64'(dec_used_rs), 64'(case_tbl[idx][COL_USED_RS]));
        check_value("dec_pc", 64'(dec_pc), 64'(case_tbl[idx][COL_PC]));
        check_value("dec_wid", 64'(dec_wid), 64'(case_tbl[idx][COL_WID]));
        check_value("dec_tmask", 64'(dec_tmask), 64'(case_tbl[idx][COL_TMASK]));
    endtask

    // Producer side, one case at a time in file order
    task automatic present_cases();
        int   gap;
        int   waited;
        logic b;
        for (int idx = 0; idx < n_cases; idx++) begin
            gap = 0;
            next_bit(prod_lfsr, b);
            while (!b && gap < 3) begin
                @(negedge clk);
                fetch_valid = 1'b0;
                #(PERIOD/4);
                check_value("sched_valid", 64'(sched_valid), 64'd0);
                gap++;
                next_bit(prod_lfsr, b);
            end
            @(negedge clk);
            fetch_valid = 1'b1;
            fetch_instr = case_tbl[idx][COL_INSTR];
            fetch_pc    = case_tbl[idx][COL_PC];
            fetch_wid   = `DEC_WID_BITS'(case_tbl[idx][COL_WID]);
            fetch_tmask = `DEC_NUM_THREADS'(case_tbl[idx][COL_TMASK]);
            #(PERIOD/4);
            waited = 0;
            while (!fetch_ready) begin  // Valid and data held while stalled
                check_value("sched_valid", 64'(sched_valid), 64'd0);
                waited++;
                if (waited > READY_TIMEOUT) fail_run("fetch_ready stayed low too long");
                @(negedge clk);
                #(PERIOD/4);
            end
            // Transfer happens at the coming rising edge
            check_value("sched_valid", 64'(sched_valid), 64'd1);
            check_value("sched_wid", 64'(sched_wid), 64'(case_tbl[idx][COL_WID]));
            check_value("sched_unlock", 64'(sched_unlock), 64'(case_tbl[idx][COL_UNLOCK]));
            expected.push_back(idx);
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        int   idle;
        logic stalled;
        logic b1;
        logic b2;
        idle    = 0;
        stalled = 1'b0;
        while (received < n_cases) begin
            @(negedge clk);
            next_bit(cons_lfsr, b1);
            next_bit(cons_lfsr, b2);
            dec_ready = b1 | b2;
            #(PERIOD/4);
            if (stalled) check_value("dec_valid", 64'(dec_valid), 64'd1);
            stalled = 1'b0;
            if (dec_valid) begin
                if (expected.size() == 0) fail_run("a decoded record came out unrequested");
                compare_record(expected[0]);
                if (dec_ready) begin
                    void'(expected.pop_front());
                    received++;
                    idle = 0;
                end else begin
                    stalled = 1'b1;
                end
            end
            idle++;
            if (idle > IDLE_TIMEOUT) fail_run("no decoded record was handed out in time");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc    = '0;
        fetch_wid   = '0;
        fetch_tmask = '0;
        dec_ready   = 1'b0;
        received    = 0;
        prod_lfsr   = 32'h7a5a;
        cons_lfsr   = 32'h7a5a;
        load_cases();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #(PERIOD/4);
        check_value("dec_valid", 64'(dec_valid), 64'd0);
        check_value("sched_valid", 64'(sched_valid), 64'd0);
        check_value("fetch_ready", 64'(fetch_ready), 64'd1);
        fork
            present_cases();
            drain_outputs();
        join
        @(negedge clk);
        #(PERIOD/4);
        check_value("dec_valid", 64'(dec_valid), 64'd0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/decode_cases.txt
# instr pc wid tmask | unit op use_imm use_pc imm wb rd rs1 rs2 used_rs unlock, all hex
# unit 0 NONE, 1 ALU, 2 BRANCH, 3 LSU, 4 CSR; used_rs is {rs2, rs1}
ffb10093 00000100 0 f  1 0 1 0 fffffffb 1 01 02 1b 1 1
405201b3 00000104 1 3  1 1 0 0 00000000 1 03 04 05 3 1
4033d313 00000108 2 1  1 7 1 0 00000003 1 06 07 03 1 1
00208033 0000010c 3 8  1 0 0 0 00000000 0 00 01 02 3 1
123452b7 00000110 0 f  1 a 1 0 12345000 1 05 08 03 0 1
80000397 00000114 1 5  1 b 1 1 80000000 1 07 00 00 0 1
fe208ce3 00000118 2 f  2 0 1 1 fffffff8 0 19 01 02 3 0
0041f863 0000011c 3 2  2 5 1 1 00000010 0 10 03 04 3 0
001000ef 00000120 0 f  2 6 1 1 00000800 1 01 00 01 0 0
00008067 00000124 1 4  2 7 1 0 00000000 0 00 01 00 1 0
00c4a403 00000128 2 f  3 2 1 0 0000000c 1 08 09 0c 1 1
fff14003 0000012c 3 6  3 4 1 0 ffffffff 0 00 02 1f 1 1
fea5ae23 00000130 0 f  3 a 1 0 fffffffc 0 1c 0b 0a 3 1
0ff0000f 00000134 1 9  3 f 0 0 00000000 0 00 00 1f 0 1
300110f3 00000138 2 f  4 1 0 0 00000300 1 01 02 00 1 1
003022f3 0000013c 3 1  4 2 0 0 00000003 1 05 00 03 1 0
3402f073 00000140 0 f  4 3 1 0 00000340 0 00 05 00 0 1
00000073 00000144 1 7  2 8 1 1 00000004 0 00 00 00 0 0
00100073 00000148 2 f  2 9 1 1 00000004 0 00 00 01 0 0
30200073 0000014c 3 c  2 a 1 1 00000004 0 00 00 02 0 0
0020a0ab 00000150 0 f  0 0 0 0 00000000 0 01 01 02 0 1

//--- decode_stage.f
+incdir+design
design/rv_isa_pkg.sv
design/decode_pkg.sv
design/dec_ctrl_if.sv
design/decode_ctrl.sv
design/imm_gen.sv
design/op_decode.sv
design/decode_out_buf.sv
design/decode_top.sv
test/tb_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the decode stage testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_decode \
    -f decode_stage.f -Mdir obj_dir \
    && ./obj_dir/Vtb_decode \
    || { echo "decode stage simulation did not pass"; exit 1; }
